//--- Makefile
TOP       ?= tb_mmu
VERILATOR ?= verilator
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module addr_xlate #(
    // 1 for the fetch path, 0 for load/store
    parameter bit IS_FETCH = 1'b0
) (
    input  wire [31:0]                  va,
    input  wire                         store,
    input  wire [1:0]                   cur_plv,
    input  wire tlb_pkg::tlb_result_t   result,
    output tlb_pkg::xlate_resp_t        resp
);

    import tlb_pkg::*;

    ecode_t inv_code;
    logic   is_4m;

    assign is_4m = result.ps == `PS_4M;

    // page invalid code by access kind
    always_comb begin
        if (IS_FETCH) begin
            inv_code = ecode_page_inv_fetch;
        end else if (store) begin
            inv_code = ecode_page_inv_store;
        end else begin
            inv_code = ecode_page_inv_load;
        end
    end

    always_comb begin
        if (is_4m) begin
            resp.pa = {result.ppn[19:9], va[20:0]};
        end else begin
            resp.pa = {result.ppn, va[11:0]};
        end
        resp.mat = result.mat;
    end

    // first failing check wins
    always_comb begin
        if (!result.found) begin
            resp.ecode = ecode_tlb_refill;
        end else if (!result.v) begin
            resp.ecode = inv_code;
        end else if (cur_plv > result.plv) begin
            resp.ecode = ecode_page_priv;
        end else if (store && !result.d) begin
            resp.ecode = ecode_page_modify;
        end else begin
            resp.ecode = ecode_none;
        end
    end

endmodule

`default_nettype wire

//--- logic/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module mmu_top (
    input  wire                         clk,
    input  wire                         reset,

    input  wire [31:0]                  fetch_va,
    input  wire [31:0]                  data_va,
    input  wire                         data_store,
    input  wire [9:0]                   cur_asid,
    input  wire [1:0]                   cur_plv,

    input  wire                         invtlb_valid,
    input  wire [4:0]                   invtlb_op,
    input  wire [9:0]                   invtlb_asid,
    input  wire [31:0]                  invtlb_va,

    input  wire                         op_valid,
    input  wire tlb_pkg::tlb_op_t       op_code,
    input  wire tlb_pkg::tlb_csr_t      csr,

    output tlb_pkg::xlate_resp_t        fetch_resp,
    output tlb_pkg::xlate_resp_t        data_resp,
    output logic                        op_done,
    output logic                        srch_found,
    output logic [`TLBIDLEN-1:0]        srch_index,
    output tlb_pkg::tlb_entry_t         rd_entry
);

    import tlb_pkg::*;

    tlb_result_t          s0_result;
    tlb_result_t          s1_result;
    tlb_result_t          s2_result;
    logic [18:0]          s2_vppn;
    logic                 s2_va_bit12;
    logic [9:0]           s2_asid;
    logic                 we;
    logic [`TLBIDLEN-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [`TLBIDLEN-1:0] r_index;
    tlb_entry_t           r_entry;

    tlb u_tlb (
        .clk          (clk),
        .reset        (reset),
        .s0_vppn      (fetch_va[31:13]),
        .s0_va_bit12  (fetch_va[12]),
        .s0_asid      (cur_asid),
        .s0_result    (s0_result),
        .s1_vppn      (data_va[31:13]),
        .s1_va_bit12  (data_va[12]),
        .s1_asid      (cur_asid),
        .s1_result    (s1_result),
        .s2_vppn      (s2_vppn),
        .s2_va_bit12  (s2_va_bit12),
        .s2_asid      (s2_asid),
        .s2_result    (s2_result),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .invtlb_asid  (invtlb_asid),
        .invtlb_va    (invtlb_va),
        .we           (we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .r_entry      (r_entry)
    );

    // fetch never stores
    addr_xlate #(.IS_FETCH(1'b1)) u_fetch_xlate (
        .va      (fetch_va),
        .store   (1'b0),
        .cur_plv (cur_plv),
        .result  (s0_result),
        .resp    (fetch_resp)
    );

    addr_xlate #(.IS_FETCH(1'b0)) u_data_xlate (
        .va      (data_va),
        .store   (data_store),
        .cur_plv (cur_plv),
        .result  (s1_result),
        .resp    (data_resp)
    );

    tlb_maint_ctrl u_maint (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .csr         (csr),
        .op_done     (op_done),
        .srch_found  (srch_found),
        .srch_index  (srch_index),
        .rd_entry    (rd_entry),
        .s2_vppn     (s2_vppn),
        .s2_va_bit12 (s2_va_bit12),
        .s2_asid     (s2_asid),
        .s2_result   (s2_result),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry)
    );

endmodule

`default_nettype wire

//--- logic/tlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb (
    input  wire                         clk,
    input  wire                         reset,

    // fetch search
    input  wire [18:0]                  s0_vppn,
    input  wire                         s0_va_bit12,
    input  wire [9:0]                   s0_asid,
    output tlb_pkg::tlb_result_t        s0_result,

    // load/store search
    input  wire [18:0]                  s1_vppn,
    input  wire                         s1_va_bit12,
    input  wire [9:0]                   s1_asid,
    output tlb_pkg::tlb_result_t        s1_result,

    // maintenance search
    input  wire [18:0]                  s2_vppn,
    input  wire                         s2_va_bit12,
    input  wire [9:0]                   s2_asid,
    output tlb_pkg::tlb_result_t        s2_result,

    input  wire                         invtlb_valid,
    input  wire [4:0]                   invtlb_op,
    input  wire [9:0]                   invtlb_asid,
    input  wire [31:0]                  invtlb_va,

    input  wire                         we,
    input  wire [`TLBIDLEN-1:0]         w_index,
    input  wire tlb_pkg::tlb_entry_t    w_entry,

    input  wire [`TLBIDLEN-1:0]         r_index,
    output tlb_pkg::tlb_entry_t         r_entry
);

    import tlb_pkg::*;

    logic [`TLBNUM-1:0] tlb_e;
    // 1 for 4MB, 0 for 4KB
    logic [`TLBNUM-1:0] tlb_ps4mb;
    logic [`TLBNUM-1:0] tlb_g;
    logic [18:0]        tlb_vppn  [`TLBNUM];
    logic [9:0]         tlb_asid  [`TLBNUM];
    tlb_half_t          tlb_half0 [`TLBNUM];
    tlb_half_t          tlb_half1 [`TLBNUM];

    logic [`TLBNUM-1:0] inv_sel;
    logic [18:0]        invtlb_vppn;

    // 4MB pages compare only the upper ten bits
    function automatic logic vppn_hit(input logic [18:0] vppn, input int j);
        if (tlb_ps4mb[j]) begin
            return vppn[18:9] == tlb_vppn[j][18:9];
        end
        return vppn == tlb_vppn[j];
    endfunction

    function automatic tlb_result_t search(
        input logic [18:0] vppn,
        input logic        va_bit12,
        input logic [9:0]  asid
    );
        tlb_result_t          res;
        logic [`TLBNUM-1:0]   hit;
        logic [`TLBIDLEN-1:0] idx;
        logic                 odd;
        tlb_half_t            half;
        hit = '0;
        idx = '0;
        for (int i = 0; i < `TLBNUM; i++) begin
            hit[i] = tlb_e[i] && vppn_hit(vppn, i) && (asid == tlb_asid[i] || tlb_g[i]);
            if (hit[i]) begin
                idx = idx | `TLBIDLEN'(i);
            end
        end
        // odd page select depends on page size
        odd = tlb_ps4mb[idx] ? vppn[8] : va_bit12;
        half = odd ? tlb_half1[idx] : tlb_half0[idx];
        res.found = |hit;
        res.index = idx;
        res.ppn = half.ppn;
        res.ps = tlb_ps4mb[idx] ? `PS_4M : `PS_4K;
        res.plv = half.plv;
        res.mat = half.mat;
        res.d = half.d;
        res.v = half.v;
        return res;
    endfunction

    always_comb begin
        s0_result = search(s0_vppn, s0_va_bit12, s0_asid);
        s1_result = search(s1_vppn, s1_va_bit12, s1_asid);
        s2_result = search(s2_vppn, s2_va_bit12, s2_asid);
    end

    assign invtlb_vppn = invtlb_va[31:13];

    // entries selected by the invtlb op
    always_comb begin
        for (int j = 0; j < `TLBNUM; j++) begin
            case (invtlb_op)
                5'd0, 5'd1: inv_sel[j] = 1'b1;
                5'd2:       inv_sel[j] = tlb_g[j];
                5'd3:       inv_sel[j] = !tlb_g[j];
                5'd4:       inv_sel[j] = !tlb_g[j] && tlb_asid[j] == invtlb_asid;
                5'd5: begin
                    inv_sel[j] = !tlb_g[j] && tlb_asid[j] == invtlb_asid
                                 && vppn_hit(invtlb_vppn, j);
                end
                5'd6: begin
                    inv_sel[j] = (tlb_g[j] || tlb_asid[j] == invtlb_asid)
                                 && vppn_hit(invtlb_vppn, j);
                end
                default:    inv_sel[j] = 1'b0;
            endcase
        end
    end

    // invtlb wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            tlb_e <= '0;
        end else if (invtlb_valid) begin
            tlb_e <= tlb_e & ~inv_sel;
        end else if (we) begin
            tlb_e[w_index] <= w_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we && !invtlb_valid) begin
            tlb_ps4mb[w_index] <= w_entry.ps != `PS_4K;
            tlb_g[w_index]     <= w_entry.g;
            tlb_vppn[w_index]  <= w_entry.vppn;
            tlb_asid[w_index]  <= w_entry.asid;
            tlb_half0[w_index] <= w_entry.half0;
            tlb_half1[w_index] <= w_entry.half1;
        end
    end

    // read port
    always_comb begin
        r_entry.e     = tlb_e[r_index];
        r_entry.vppn  = tlb_vppn[r_index];
        r_entry.ps    = tlb_ps4mb[r_index] ? `PS_4M : `PS_4K;
        r_entry.asid  = tlb_asid[r_index];
        r_entry.g     = tlb_g[r_index];
        r_entry.half0 = tlb_half0[r_index];
        r_entry.half1 = tlb_half1[r_index];
    end

endmodule

`default_nettype wire

//--- logic/tlb_macros.svh
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// table size and the matching index width
`define TLBNUM   16
`define TLBIDLEN 4

// page size codes as held in entry.ps
`define PS_4K    6'd12
`define PS_4M    6'd21

`endif

//--- logic/tlb_maint_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_maint_ctrl (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         op_valid,
    input  wire tlb_pkg::tlb_op_t       op_code,
    input  wire tlb_pkg::tlb_csr_t      csr,

    output logic                        op_done,
    output logic                        srch_found,
    output logic [`TLBIDLEN-1:0]        srch_index,
    output tlb_pkg::tlb_entry_t         rd_entry,

    // search port 2
    output logic [18:0]                 s2_vppn,
    output logic                        s2_va_bit12,
    output logic [9:0]                  s2_asid,
    input  wire tlb_pkg::tlb_result_t   s2_result,

    // write and read ports
    output logic                        we,
    output logic [`TLBIDLEN-1:0]        w_index,
    output tlb_pkg::tlb_entry_t         w_entry,
    output logic [`TLBIDLEN-1:0]        r_index,
    input  wire tlb_pkg::tlb_entry_t    r_entry
);

    import tlb_pkg::*;

    logic                 do_srch;
    logic                 do_rd;
    logic                 do_fill;
    logic [`TLBIDLEN-1:0] fill_idx;

    assign do_srch = op_valid && op_code == op_srch;
    assign do_rd   = op_valid && op_code == op_rd;
    assign do_fill = op_valid && op_code == op_fill;

    // tlbsrch looks up ehi under the current asid
    assign s2_vppn     = csr.ehi_vppn;
    assign s2_va_bit12 = 1'b0;
    assign s2_asid     = csr.asid;

    assign r_index = csr.idx_index;

    // entry assembled from the staged csr values
    always_comb begin
        w_entry.e          = !csr.idx_ne;
        w_entry.vppn       = csr.ehi_vppn;
        w_entry.ps         = csr.idx_ps;
        w_entry.asid       = csr.asid;
        w_entry.g          = csr.elo0.g && csr.elo1.g;
        w_entry.half0.ppn  = csr.elo0.ppn;
        w_entry.half0.plv  = csr.elo0.plv;
        w_entry.half0.mat  = csr.elo0.mat;
        w_entry.half0.d    = csr.elo0.d;
        w_entry.half0.v    = csr.elo0.v;
        w_entry.half1.ppn  = csr.elo1.ppn;
        w_entry.half1.plv  = csr.elo1.plv;
        w_entry.half1.mat  = csr.elo1.mat;
        w_entry.half1.d    = csr.elo1.d;
        w_entry.half1.v    = csr.elo1.v;
    end

    assign we      = op_valid && (op_code == op_wr || op_code == op_fill);
    assign w_index = do_fill ? fill_idx : csr.idx_index;

    // round-robin fill slot
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_idx <= '0;
        end else if (do_fill) begin
            if (fill_idx == `TLBIDLEN'(`TLBNUM - 1)) begin
                fill_idx <= '0;
            end else begin
                fill_idx <= fill_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_done    <= 1'b0;
            srch_found <= 1'b0;
            srch_index <= '0;
            rd_entry   <= '0;
        end else begin
            op_done <= op_valid;
            if (do_srch) begin
                srch_found <= s2_result.found;
                srch_index <= s2_result.index;
            end
            // disabled entries read back as all zero
            if (do_rd) begin
                rd_entry <= r_entry.e ? r_entry : '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tlb_pkg.sv
`default_nettype none

`include "tlb_macros.svh"

package tlb_pkg;

    // one half of a dual-page entry
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_half_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        tlb_half_t   half0;
        tlb_half_t   half1;
    } tlb_entry_t;

    // selected half of the matching entry
    typedef struct packed {
        logic                 found;
        logic [`TLBIDLEN-1:0] index;
        logic [19:0]          ppn;
        logic [5:0]           ps;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_result_t;

    // LoongArch ecode values
    typedef enum logic [5:0] {
        ecode_none           = 6'h00,
        ecode_page_inv_load  = 6'h01,
        ecode_page_inv_store = 6'h02,
        ecode_page_inv_fetch = 6'h03,
        ecode_page_modify    = 6'h04,
        ecode_page_priv      = 6'h07,
        ecode_tlb_refill     = 6'h3f
    } ecode_t;

    typedef struct packed {
        logic [31:0] pa;
        ecode_t      ecode;
        logic [1:0]  mat;
    } xlate_resp_t;

    // tlbelo0/1 layout
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
        logic        g;
    } tlb_elo_t;

    typedef struct packed {
        logic [18:0]          ehi_vppn;
        logic [`TLBIDLEN-1:0] idx_index;
        logic [5:0]           idx_ps;
        logic                 idx_ne;
        tlb_elo_t             elo0;
        tlb_elo_t             elo1;
        logic [9:0]           asid;
    } tlb_csr_t;

    typedef enum logic [1:0] {
        op_srch,
        op_rd,
        op_wr,
        op_fill
    } tlb_op_t;

endpackage

`default_nettype wire

//--- sim.f
+incdir+logic
logic/tlb_pkg.sv
logic/tlb.sv
logic/addr_xlate.sv
logic/tlb_maint_ctrl.sv
logic/mmu_top.sv
sim/mmu_properties.sv
sim/tb_mmu.sv

//--- sim/mmu_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module mmu_properties (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         op_valid,
    input  wire tlb_pkg::tlb_op_t       op_code,
    input  wire                         invtlb_valid,
    input  wire                         op_done,
    input  wire                         srch_found,
    input  wire [`TLBIDLEN-1:0]         srch_index,
    input  wire                         we,
    input  wire [`TLBIDLEN-1:0]         w_index,
    input  wire                         w_entry_e,
    input  wire [`TLBNUM-1:0]           tlb_e
);

    import tlb_pkg::*;

    logic               srch_op;
    logic [`TLBNUM-1:0] wr_mask;

    // a search with no invtlb in the same cycle
    assign srch_op = op_valid && op_code == op_srch && !invtlb_valid;

    // the only slot a write may enable
    assign wr_mask = (we && w_entry_e && !invtlb_valid) ? (`TLBNUM'(1) << w_index) : '0;

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        op_done == $past(op_valid))
        else $error("op_done does not follow op_valid by one cycle");

    srch_hit_enabled: assert property (@(posedge clk) disable iff (reset)
        !($past(srch_op) && srch_found) || tlb_e[srch_index])
        else $error("search reported a hit on a disabled entry");

    no_phantom_entry: assert property (@(posedge clk) disable iff (reset)
        (tlb_e & ~$past(tlb_e) & ~$past(wr_mask)) == '0)
        else $error("an entry became enabled without being written");

endmodule

bind mmu_top mmu_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .op_valid     (op_valid),
    .op_code      (op_code),
    .invtlb_valid (invtlb_valid),
    .op_done      (op_done),
    .srch_found   (srch_found),
    .srch_index   (srch_index),
    .we           (we),
    .w_index      (w_index),
    .w_entry_e    (w_entry.e),
    .tlb_e        (u_tlb.tlb_e)
);

`default_nettype wire

//--- sim/tb_mmu.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tb_mmu;

    import tlb_pkg::*;

    localparam int TIMEOUT = 20;

    logic                 clk;
    logic                 reset;
    logic [31:0]          fetch_va;
    logic [31:0]          data_va;
    logic                 data_store;
    logic [9:0]           cur_asid;
    logic [1:0]           cur_plv;
    logic                 invtlb_valid;
    logic [4:0]           invtlb_op;
    logic [9:0]           invtlb_asid;
    logic [31:0]          invtlb_va;
    logic                 op_valid;
    tlb_op_t              op_code;
    tlb_csr_t             csr;
    xlate_resp_t          fetch_resp;
    xlate_resp_t          data_resp;
    logic                 op_done;
    logic                 srch_found;
    logic [`TLBIDLEN-1:0] srch_index;
    tlb_entry_t           rd_entry;

    // entries as the testbench wrote them
    tlb_entry_t           model [`TLBNUM];
    int                   fill_count;
    integer               seed;

    mmu_top UUT (
        .clk          (clk),
        .reset        (reset),
        .fetch_va     (fetch_va),
        .data_va      (data_va),
        .data_store   (data_store),
        .cur_asid     (cur_asid),
        .cur_plv      (cur_plv),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .invtlb_asid  (invtlb_asid),
        .invtlb_va    (invtlb_va),
        .op_valid     (op_valid),
        .op_code      (op_code),
        .csr          (csr),
        .fetch_resp   (fetch_resp),
        .data_resp    (data_resp),
        .op_done      (op_done),
        .srch_found   (srch_found),
        .srch_index   (srch_index),
        .rd_entry     (rd_entry)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic vppn_match(input int i, input logic [18:0] vppn);
        if (model[i].ps == `PS_4M) begin
            return vppn[18:9] == model[i].vppn[18:9];
        end
        return vppn == model[i].vppn;
    endfunction

    function automatic logic model_hit(input int i, input logic [18:0] vppn,
                                       input logic [9:0] asid);
        return model[i].e && (model[i].g || model[i].asid == asid) && vppn_match(i, vppn);
    endfunction

    // expected translation from the model and the access checks
    function automatic xlate_resp_t expected_resp(input logic [31:0] va, input logic is_fetch,
                                                  input logic store);
        xlate_resp_t r;
        tlb_half_t   h;
        logic        big;
        int          i;
        r = '0;
        r.ecode = ecode_tlb_refill;
        for (i = 0; i < `TLBNUM; i++) begin
            if (model_hit(i, va[31:13], cur_asid)) begin
                big = model[i].ps == `PS_4M;
                h = (big ? va[21] : va[12]) ? model[i].half1 : model[i].half0;
                r.mat = h.mat;
                r.pa = big ? {h.ppn[19:9], va[20:0]} : {h.ppn, va[11:0]};
                if (!h.v) begin
                    r.ecode = is_fetch ? ecode_page_inv_fetch :
                              (store ? ecode_page_inv_store : ecode_page_inv_load);
                end else if (cur_plv > h.plv) begin
                    r.ecode = ecode_page_priv;
                end else if (store && !h.d) begin
                    r.ecode = ecode_page_modify;
                end else begin
                    r.ecode = ecode_none;
                end
            end
        end
        return r;
    endfunction

    function automatic tlb_entry_t random_entry(input int idx, input logic [5:0] ps,
                                                input logic [9:0] asid, input logic g);
        tlb_entry_t  ent;
        logic [95:0] bits;
        bits = {$random(seed), $random(seed), $random(seed)};
        ent = bits[$bits(tlb_entry_t)-1:0];
        ent.e = 1'b1;
        // index in the tag keeps live entries from overlapping
        ent.vppn = {1'b1, idx[3:0], bits[13:0]};
        ent.ps = ps;
        ent.asid = asid;
        ent.g = g;
        ent.half0.plv = 2'd3;
        ent.half0.v = 1'b1;
        ent.half0.d = 1'b1;
        ent.half1.plv = 2'd3;
        ent.half1.v = 1'b1;
        ent.half1.d = 1'b1;
        return ent;
    endfunction

    // random VA inside one half of a modelled entry
    function automatic logic [31:0] va_in(input int idx, input logic odd);
        logic [31:0] r;
        r = $random(seed);
        if (model[idx].ps == `PS_4M) begin
            return {model[idx].vppn[18:9], odd, r[20:0]};
        end
        return {model[idx].vppn, odd, r[11:0]};
    endfunction

    task automatic run_op(input tlb_op_t code, input tlb_csr_t c);
        int n;
        @(posedge clk);
        #1;
        csr = c;
        op_code = code;
        op_valid = 1'b1;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        n = 0;
        while (!op_done) begin
            if (n == TIMEOUT) begin
                report_failure("op_done never arrived after a maintenance strobe");
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic set_mode(input logic [9:0] asid, input logic [1:0] plv);
        @(posedge clk);
        #1;
        cur_asid = asid;
        cur_plv = plv;
    endtask

    task automatic write_entry(input tlb_op_t code, input tlb_entry_t ent, input int idx);
        tlb_csr_t c;
        c.ehi_vppn = ent.vppn;
        c.idx_index = idx[`TLBIDLEN-1:0];
        c.idx_ps = ent.ps;
        c.idx_ne = !ent.e;
        c.elo0 = {ent.half0, ent.g};
        c.elo1 = {ent.half1, ent.g};
        c.asid = ent.asid;
        run_op(code, c);
        if (code == op_fill) begin
            model[fill_count] = ent;
            fill_count = (fill_count + 1) % `TLBNUM;
        end else begin
            model[idx] = ent;
        end
    endtask

    task automatic fill_one;
        tlb_entry_t ent;
        // mix of page sizes, asids and global entries
        ent = random_entry(fill_count, fill_count[0] ? `PS_4M : `PS_4K,
                           fill_count[1] ? 10'h21 : 10'h3a, fill_count % 4 == 0);
        write_entry(op_fill, ent, 0);
    endtask

    task automatic check_read(input int idx);
        tlb_csr_t   c;
        tlb_entry_t exp;
        c = '0;
        c.idx_index = idx[`TLBIDLEN-1:0];
        run_op(op_rd, c);
        exp = model[idx].e ? model[idx] : '0;
        check($sformatf("rd_entry[%0d]", idx), 128'(rd_entry), 128'(exp));
    endtask

    task automatic compare_resp(input string name, input xlate_resp_t actual,
                                input xlate_resp_t expected);
        check({name, ".ecode"}, 128'(actual.ecode), 128'(expected.ecode));
        if (expected.ecode != ecode_tlb_refill) begin
            check({name, ".pa"}, 128'(actual.pa), 128'(expected.pa));
            check({name, ".mat"}, 128'(actual.mat), 128'(expected.mat));
        end
    endtask

    task automatic check_translation(input logic [31:0] va, input logic store);
        xlate_resp_t exp_f;
        xlate_resp_t exp_d;
        exp_f = expected_resp(va, 1'b1, 1'b0);
        exp_d = expected_resp(va, 1'b0, store);
        @(posedge clk);
        #1;
        fetch_va = va;
        data_va = va;
        data_store = store;
        #1;
        compare_resp("fetch_resp", fetch_resp, exp_f);
        compare_resp("data_resp", data_resp, exp_d);
    endtask

    task automatic check_search(input logic [18:0] vppn, input logic [9:0] asid);
        tlb_csr_t c;
        logic     found;
        int       idx;
        int       i;
        c = '0;
        c.ehi_vppn = vppn;
        c.asid = asid;
        found = 1'b0;
        idx = 0;
        for (i = 0; i < `TLBNUM; i++) begin
            if (model_hit(i, vppn, asid)) begin
                found = 1'b1;
                idx = i;
            end
        end
        run_op(op_srch, c);
        check("srch_found", 128'(srch_found), 128'(found));
        if (found) begin
            check("srch_index", 128'(srch_index), 128'(idx[`TLBIDLEN-1:0]));
        end
    endtask

    task automatic run_invtlb(input logic [4:0] op, input logic [9:0] asid,
                              input logic [31:0] va);
        logic sel;
        int   i;
        @(posedge clk);
        #1;
        invtlb_valid = 1'b1;
        invtlb_op = op;
        invtlb_asid = asid;
        invtlb_va = va;
        @(posedge clk);
        #1;
        invtlb_valid = 1'b0;
        for (i = 0; i < `TLBNUM; i++) begin
            case (op)
                5'd0, 5'd1: sel = 1'b1;
                5'd2:       sel = model[i].g;
                5'd3:       sel = !model[i].g;
                5'd4:       sel = !model[i].g && model[i].asid == asid;
                5'd5: begin
                    sel = !model[i].g && model[i].asid == asid && vppn_match(i, va[31:13]);
                end
                5'd6: begin
                    sel = (model[i].g || model[i].asid == asid) && vppn_match(i, va[31:13]);
                end
                default:    sel = 1'b0;
            endcase
            if (sel) begin
                model[i].e = 1'b0;
            end
        end
    endtask

    task automatic verify_table;
        int i;
        for (i = 0; i < `TLBNUM; i++) begin
            check_read(i);
            check_translation(va_in(i, i[0]), 1'b0);
        end
    endtask

    task automatic test_reset_state;
        int i;
        for (i = 0; i < 4; i++) begin
            check_translation($random(seed), i[0]);
        end
        for (i = 0; i < `TLBNUM; i++) begin
            check_read(i);
        end
    endtask

    task automatic test_write_read;
        tlb_entry_t  ent;
        logic [31:0] va;
        ent = random_entry(3, `PS_4K, 10'h21, 1'b0);
        write_entry(op_wr, ent, 3);
        check_read(3);
        check_translation(va_in(3, 1'b0), 1'b0);
        va = va_in(3, 1'b1);
        check_translation(va, 1'b0);
        check("fetch_resp.pa", 128'(fetch_resp.pa), 128'({ent.half1.ppn, va[11:0]}));
    endtask

    task automatic test_4m_and_exceptions;
        tlb_entry_t  ent;
        logic [31:0] va;
        ent = random_entry(5, `PS_4M, 10'h21, 1'b0);
        write_entry(op_wr, ent, 5);
        check_read(5);
        va = va_in(5, 1'b1);
        check_translation(va, 1'b1);
        check("data_resp.pa", 128'(data_resp.pa), 128'({ent.half1.ppn[19:9], va[20:0]}));
        // even half invalid, both halves low plv and clean
        ent = random_entry(6, `PS_4K, 10'h21, 1'b0);
        ent.half0.v = 1'b0;
        ent.half0.plv = 2'd1;
        ent.half0.d = 1'b0;
        ent.half1.plv = 2'd1;
        ent.half1.d = 1'b0;
        write_entry(op_wr, ent, 6);
        check_translation(va_in(6, 1'b0), 1'b1);
        check("fetch_resp.ecode", 128'(fetch_resp.ecode), 128'(ecode_page_inv_fetch));
        check("data_resp.ecode", 128'(data_resp.ecode), 128'(ecode_page_inv_store));
        check_translation(va_in(6, 1'b0), 1'b0);
        check("data_resp.ecode", 128'(data_resp.ecode), 128'(ecode_page_inv_load));
        set_mode(10'h21, 2'd3);
        check_translation(va_in(6, 1'b0), 1'b1);
        check("data_resp.ecode", 128'(data_resp.ecode), 128'(ecode_page_inv_store));
        check_translation(va_in(6, 1'b1), 1'b1);
        check("data_resp.ecode", 128'(data_resp.ecode), 128'(ecode_page_priv));
        set_mode(10'h21, 2'd1);
        check_translation(va_in(6, 1'b1), 1'b1);
        check("data_resp.ecode", 128'(data_resp.ecode), 128'(ecode_page_modify));
        set_mode(10'h21, 2'd0);
    endtask

    task automatic test_asid_global;
        write_entry(op_wr, random_entry(7, `PS_4K, 10'h21, 1'b0), 7);
        write_entry(op_wr, random_entry(8, `PS_4M, 10'h21, 1'b1), 8);
        set_mode(10'h155, 2'd0);
        check_translation(va_in(7, 1'b0), 1'b0);
        check("fetch_resp.ecode", 128'(fetch_resp.ecode), 128'(ecode_tlb_refill));
        check_translation(va_in(8, 1'b1), 1'b0);
        check_search(model[7].vppn, 10'h155);
        check_search(model[8].vppn, 10'h155);
        check_search(model[7].vppn, 10'h21);
        check_search(19'h0_1234, 10'h21);
        set_mode(10'h21, 2'd0);
    endtask

    task automatic test_fill;
        int i;
        for (i = 0; i < `TLBNUM; i++) begin
            fill_one();
        end
        verify_table();
        // two more fills wrap onto slots 0 and 1
        fill_one();
        fill_one();
        for (i = 0; i < 3; i++) begin
            check_read(i);
        end
        // slot 0 is global, so only the new tag hits
        check_translation(va_in(0, 1'b1), 1'b0);
    endtask

    task automatic test_invtlb;
        logic [4:0] ops [6];
        int         n;
        int         i;
        ops = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6};
        for (n = 0; n < 6; n++) begin
            for (i = 0; i < `TLBNUM; i++) begin
                fill_one();
            end
            // slot 6 is private to asid 21, slot 8 is global
            run_invtlb(ops[n], 10'h21, ops[n] == 5'd6 ? va_in(8, 1'b0) : va_in(6, 1'b0));
            verify_table();
        end
    endtask

    initial begin
        int i;
        seed = 32'hec7;
        reset = 1'b1;
        fetch_va = '0;
        data_va = '0;
        data_store = 1'b0;
        cur_asid = 10'h21;
        cur_plv = 2'd0;
        invtlb_valid = 1'b0;
        invtlb_op = '0;
        invtlb_asid = '0;
        invtlb_va = '0;
        op_valid = 1'b0;
        op_code = op_srch;
        csr = '0;
        fill_count = 0;
        for (i = 0; i < `TLBNUM; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_write_read();
        test_4m_and_exceptions();
        test_asid_global();
        test_fill();
        test_invtlb();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
